// ==== src/noc_pkg.sv ====
package noc_pkg;

	// flit format
	localparam int flit_width = 8;
	localparam int dest_width = 4;

	// packet and buffer sizing
	localparam int packet_flits = 8;
	localparam int buf_addr_width = $clog2(packet_flits);

	// router radix, same count of inputs and outputs
	localparam int num_ports = 2;
	localparam int port_sel_width = $clog2(num_ports);

	typedef logic [port_sel_width-1:0] port_sel_t;

	// head flit: top bit set, destination in the low nibble
	typedef struct packed {
		logic is_head;
		logic [flit_width-dest_width-2:0] rsvd;
		logic [dest_width-1:0] dest;
	} head_flit_t;

	// body flit: top bit clear, rest is payload
	typedef struct packed {
		logic is_head;
		logic [flit_width-2:0] payload;
	} body_flit_t;

	// one flit word, two decodings
	typedef union packed {
		head_flit_t head_view;
		body_flit_t body_view;
	} flit_t;

endpackage

// ==== src/sw_if.sv ====
`timescale 1ns/10ps

interface sw_if;

	import noc_pkg::*;

	// switch request and grant
	logic req;
	port_sel_t chnl;
	logic gnt;

	// packet buffer read port, driven by the granted transmitter
	logic [buf_addr_width-1:0] buf_addr;
	flit_t buf_data;

	modport rx (
		output req, chnl, buf_data,
		input gnt, buf_addr
	);

	modport alloc (
		input req, chnl, buf_data,
		output gnt, buf_addr
	);

endinterface

// ==== src/route_table.sv ====
`timescale 1ns/10ps

module route_table (
	input logic clk,
	input logic reset,
	input logic we,
	input logic [noc_pkg::dest_width-1:0] waddr,
	input noc_pkg::port_sel_t wport,
	input logic [noc_pkg::dest_width-1:0] raddr0,
	input logic [noc_pkg::dest_width-1:0] raddr1,
	output noc_pkg::port_sel_t rport0,
	output noc_pkg::port_sel_t rport1
);

	import noc_pkg::*;

	// one output port per destination
	port_sel_t entries [2**dest_width];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// all destinations start on output 0
			for (int i = 0; i < 2**dest_width; i++) begin
				entries[i] <= '0;
			end
			rport0 <= '0;
			rport1 <= '0;
		end else begin
			if (we) begin
				entries[waddr] <= wport;
			end
			// registered lookups, one per input port
			rport0 <= entries[raddr0];
			rport1 <= entries[raddr1];
		end
	end

endmodule

// ==== src/rx_port.sv ====
`timescale 1ns/10ps

module rx_port (
	input logic clk,
	input logic reset,
	input logic ch_req,
	input noc_pkg::flit_t ch_flit,
	output logic ch_ack,
	output logic [noc_pkg::dest_width-1:0] table_addr,
	input noc_pkg::port_sel_t table_port,
	sw_if.rx sw
);

	import noc_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_latched,
		st_route,
		st_buffer,
		st_wait_gnt,
		st_send
	} rx_state_t;

	rx_state_t state;

	// request synchronizer and edge detect
	logic req_s1;
	logic req_s2;
	logic req_old;
	logic req_edge;

	flit_t flit_q;
	port_sel_t out_port;
	logic [buf_addr_width-1:0] flit_cnt;
	flit_t buf_mem [packet_flits];

	assign req_edge = req_s2 ^ req_old;

	// lookup address comes straight from the held head flit
	assign table_addr = flit_q.head_view.dest;

	// transmitter reads the buffer combinationally
	assign sw.buf_data = buf_mem[sw.buf_addr];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			req_s1 <= 1'b0;
			req_s2 <= 1'b0;
			req_old <= 1'b0;
		end else begin
			req_s1 <= ch_req;
			req_s2 <= req_s1;
			req_old <= req_s2;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			ch_ack <= 1'b0;
			flit_q <= '0;
			out_port <= '0;
			flit_cnt <= '0;
			sw.req <= 1'b0;
			sw.chnl <= '0;
			for (int i = 0; i < packet_flits; i++) begin
				buf_mem[i] <= '0;
			end
		end else begin
			case (state)
				st_idle: begin
					if (req_edge) begin
						flit_q <= ch_flit;
						state <= st_latched;
					end
				end
				st_latched: begin
					// head flits need a table lookup first
					if (flit_q.head_view.is_head) begin
						state <= st_route;
					end else begin
						state <= st_buffer;
					end
				end
				st_route: begin
					out_port <= table_port;
					state <= st_buffer;
				end
				st_buffer: begin
					buf_mem[flit_cnt] <= flit_q;
					if (flit_cnt != buf_addr_width'(packet_flits - 1)) begin
						flit_cnt <= flit_cnt + 1'b1;
						ch_ack <= ~ch_ack;
						state <= st_idle;
					end else begin
						// packet complete, last ack held until it has left
						sw.req <= 1'b1;
						sw.chnl <= out_port;
						state <= st_wait_gnt;
					end
				end
				st_wait_gnt: begin
					if (sw.gnt) begin
						state <= st_send;
					end
				end
				st_send: begin
					// grant falls once the last flit is taken downstream
					if (!sw.gnt) begin
						sw.req <= 1'b0;
						ch_ack <= ~ch_ack;
						flit_cnt <= '0;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// ==== src/tx_port.sv ====
`timescale 1ns/10ps

module tx_port (
	input logic clk,
	input logic reset,
	input logic start,
	output logic [noc_pkg::buf_addr_width-1:0] rd_addr,
	input noc_pkg::flit_t rd_data,
	output logic done,
	output logic ch_req,
	output noc_pkg::flit_t ch_flit,
	input logic ch_ack
);

	import noc_pkg::*;

	// ack synchronizer and edge detect
	logic ack_s1;
	logic ack_s2;
	logic ack_old;
	logic ack_edge;

	logic active;
	// index of the flit currently on the channel
	logic [buf_addr_width-1:0] flit_cnt;

	assign ack_edge = ack_s2 ^ ack_old;

	// look one flit ahead so the next one goes out right after the ack
	assign rd_addr = active ? flit_cnt + 1'b1 : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_s1 <= 1'b0;
			ack_s2 <= 1'b0;
			ack_old <= 1'b0;
		end else begin
			ack_s1 <= ch_ack;
			ack_s2 <= ack_s1;
			ack_old <= ack_s2;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			flit_cnt <= '0;
			done <= 1'b0;
			ch_req <= 1'b0;
			ch_flit <= '0;
		end else begin
			done <= 1'b0;
			if (!active) begin
				if (start) begin
					ch_flit <= rd_data;
					ch_req <= ~ch_req;
					flit_cnt <= '0;
					active <= 1'b1;
				end
			end else if (ack_edge) begin
				if (flit_cnt == buf_addr_width'(packet_flits - 1)) begin
					// whole packet taken downstream
					active <= 1'b0;
					flit_cnt <= '0;
					done <= 1'b1;
				end else begin
					ch_flit <= rd_data;
					ch_req <= ~ch_req;
					flit_cnt <= flit_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== src/switch_alloc.sv ====
`timescale 1ns/10ps

module switch_alloc (
	input logic clk,
	input logic reset,
	sw_if.alloc rx0,
	sw_if.alloc rx1,
	output logic out0_req,
	output logic out1_req,
	output noc_pkg::flit_t out0_flit,
	output noc_pkg::flit_t out1_flit,
	input logic out0_ack,
	input logic out1_ack
);

	import noc_pkg::*;

	// per input
	logic [num_ports-1:0] req_in;
	logic [num_ports-1:0] gnt_in;
	port_sel_t chnl_in [num_ports];
	flit_t data_in [num_ports];

	// per output
	logic [num_ports-1:0] busy_q;
	logic [num_ports-1:0] release_q;
	logic [num_ports-1:0] owner_q;
	logic [num_ports-1:0] ptr_q;
	logic [num_ports-1:0] start_q;
	logic [num_ports-1:0] done;
	logic [buf_addr_width-1:0] rd_addr [num_ports];
	logic [num_ports-1:0] cand [num_ports];

	assign req_in = {rx1.req, rx0.req};
	assign chnl_in[0] = rx0.chnl;
	assign chnl_in[1] = rx1.chnl;
	assign data_in[0] = rx0.buf_data;
	assign data_in[1] = rx1.buf_data;

	assign rx0.gnt = gnt_in[0];
	assign rx1.gnt = gnt_in[1];

	// each input follows the transmitter that owns it
	assign rx0.buf_addr = (busy_q[1] && !owner_q[1]) ? rd_addr[1] : rd_addr[0];
	assign rx1.buf_addr = (busy_q[1] && owner_q[1]) ? rd_addr[1] : rd_addr[0];

	always_comb begin
		gnt_in = '0;
		for (int o = 0; o < num_ports; o++) begin
			if (busy_q[o] && !release_q[o]) begin
				gnt_in[owner_q[o]] = 1'b1;
			end
		end
		// inputs asking for this output and not already served
		for (int o = 0; o < num_ports; o++) begin
			for (int i = 0; i < num_ports; i++) begin
				cand[o][i] = req_in[i] && (chnl_in[i] == port_sel_t'(o)) && !gnt_in[i];
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy_q <= '0;
			release_q <= '0;
			owner_q <= '0;
			ptr_q <= '0;
			start_q <= '0;
		end else begin
			for (int o = 0; o < num_ports; o++) begin
				start_q[o] <= 1'b0;
				if (!busy_q[o]) begin
					if (cand[o] != '0) begin
						busy_q[o] <= 1'b1;
						start_q[o] <= 1'b1;
						if (&cand[o]) begin
							// both compete, pointer decides and then flips
							owner_q[o] <= ptr_q[o];
							ptr_q[o] <= ~ptr_q[o];
						end else begin
							owner_q[o] <= cand[o][1];
						end
					end
				end else if (release_q[o]) begin
					// one idle cycle so the old request can drop
					busy_q[o] <= 1'b0;
					release_q[o] <= 1'b0;
				end else if (done[o]) begin
					release_q[o] <= 1'b1;
				end
			end
		end
	end

	tx_port u_tx0 (
		.clk(clk),
		.reset(reset),
		.start(start_q[0]),
		.rd_addr(rd_addr[0]),
		.rd_data(data_in[owner_q[0]]),
		.done(done[0]),
		.ch_req(out0_req),
		.ch_flit(out0_flit),
		.ch_ack(out0_ack)
	);

	tx_port u_tx1 (
		.clk(clk),
		.reset(reset),
		.start(start_q[1]),
		.rd_addr(rd_addr[1]),
		.rd_data(data_in[owner_q[1]]),
		.done(done[1]),
		.ch_req(out1_req),
		.ch_flit(out1_flit),
		.ch_ack(out1_ack)
	);

endmodule

// ==== src/noc_router.sv ====
`timescale 1ns/10ps

module noc_router (
	input logic clk,
	input logic reset,
	input logic in0_req,
	input noc_pkg::flit_t in0_flit,
	output logic in0_ack,
	input logic in1_req,
	input noc_pkg::flit_t in1_flit,
	output logic in1_ack,
	output logic out0_req,
	output noc_pkg::flit_t out0_flit,
	input logic out0_ack,
	output logic out1_req,
	output noc_pkg::flit_t out1_flit,
	input logic out1_ack,
	input logic cfg_we,
	input logic [noc_pkg::dest_width-1:0] cfg_dest,
	input noc_pkg::port_sel_t cfg_port
);

	import noc_pkg::*;

	logic [dest_width-1:0] table_addr0;
	logic [dest_width-1:0] table_addr1;
	port_sel_t table_port0;
	port_sel_t table_port1;

	sw_if sw0 ();
	sw_if sw1 ();

	route_table u_route_table (
		.clk(clk),
		.reset(reset),
		.we(cfg_we),
		.waddr(cfg_dest),
		.wport(cfg_port),
		.raddr0(table_addr0),
		.raddr1(table_addr1),
		.rport0(table_port0),
		.rport1(table_port1)
	);

	rx_port u_rx0 (
		.clk(clk),
		.reset(reset),
		.ch_req(in0_req),
		.ch_flit(in0_flit),
		.ch_ack(in0_ack),
		.table_addr(table_addr0),
		.table_port(table_port0),
		.sw(sw0.rx)
	);

	rx_port u_rx1 (
		.clk(clk),
		.reset(reset),
		.ch_req(in1_req),
		.ch_flit(in1_flit),
		.ch_ack(in1_ack),
		.table_addr(table_addr1),
		.table_port(table_port1),
		.sw(sw1.rx)
	);

	switch_alloc u_switch_alloc (
		.clk(clk),
		.reset(reset),
		.rx0(sw0.alloc),
		.rx1(sw1.alloc),
		.out0_req(out0_req),
		.out1_req(out1_req),
		.out0_flit(out0_flit),
		.out1_flit(out1_flit),
		.out0_ack(out0_ack),
		.out1_ack(out1_ack)
	);

endmodule

// ==== dv/tb_noc_router.sv ====
`timescale 1ns/10ps

module tb_noc_router;

	import noc_pkg::*;

	localparam int max_tests = 64;
	localparam int flit_timeout = 60;

	logic clk;
	logic reset;
	logic in_req [num_ports];
	flit_t in_flit [num_ports];
	logic in_ack [num_ports];
	logic out_req [num_ports];
	flit_t out_flit [num_ports];
	logic out_ack [num_ports];
	logic cfg_we;
	logic [dest_width-1:0] cfg_dest;
	port_sel_t cfg_port;

	// one entry per line of the test file
	string test_name [max_tests];
	logic is_cfg [max_tests];
	int line_inp [max_tests];
	logic [dest_width-1:0] line_dest [max_tests];
	port_sel_t line_port [max_tests];
	port_sel_t exp_port [max_tests];
	flit_t flits [max_tests][packet_flits];
	int n_tests;
	int n_pkts;

	// reference table, packet queues and progress
	port_sel_t route_model [2**dest_width];
	int send_q [num_ports][$];
	int exp_q [num_ports][$];
	flit_t got [num_ports][packet_flits];
	int out_acked [num_ports];
	int pkts_done [num_ports];
	int rcv_count;
	int sent_count;
	int queued;
	integer seed = 32'h7fcb;

	noc_router u_noc_router (
		.clk(clk),
		.reset(reset),
		.in0_req(in_req[0]),
		.in0_flit(in_flit[0]),
		.in0_ack(in_ack[0]),
		.in1_req(in_req[1]),
		.in1_flit(in_flit[1]),
		.in1_ack(in_ack[1]),
		.out0_req(out_req[0]),
		.out0_flit(out_flit[0]),
		.out0_ack(out_ack[0]),
		.out1_req(out_req[1]),
		.out1_flit(out_flit[1]),
		.out1_ack(out_ack[1]),
		.cfg_we(cfg_we),
		.cfg_dest(cfg_dest),
		.cfg_port(cfg_port)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic end_in_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare_flit(string name, flit_t expected, flit_t actual);
		if (actual !== expected) begin
			$display("error in test %s: expected flit %h, actual %h", name, expected, actual);
			end_in_failure();
		end
	endtask

	task automatic compare_port(string name, port_sel_t expected, port_sel_t actual);
		if (actual !== expected) begin
			$display("error in test %s: expected output %0d, actual %0d", name, expected, actual);
			end_in_failure();
		end
	endtask

	task automatic read_tests();
		int fd;
		int n;
		int inp;
		int ep;
		string line;
		string name;
		string kind;
		logic [7:0] d;
		logic [7:0] b [packet_flits];
		fd = $fopen("dv/router_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test file dv/router_tests.txt");
			end_in_failure();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%s %s %d %h %h %h %h %h %h %h %h %h %d", name, kind,
						inp, d, b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7], ep);
					if (n != 13) begin
						$display("malformed line in test file: %s", line);
						end_in_failure();
					end
					test_name[n_tests] = name;
					is_cfg[n_tests] = (kind == "c");
					line_inp[n_tests] = inp;
					line_dest[n_tests] = d[dest_width-1:0];
					line_port[n_tests] = port_sel_t'(ep);
					for (int k = 0; k < packet_flits; k++) begin
						flits[n_tests][k] = b[k];
					end
					if (kind != "c") begin
						n_pkts++;
					end
					n_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	function automatic bit same_packet(int o, int t);
		for (int k = 0; k < packet_flits; k++) begin
			if (got[o][k] !== flits[t][k]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// the packet in flight from each input is the front of its queue
	task automatic find_source(input int o, output int src);
		int t;
		src = -1;
		for (int i = 0; i < num_ports; i++) begin
			if (src < 0 && exp_q[i].size() > 0) begin
				if (same_packet(o, exp_q[i][0])) begin
					src = i;
				end
			end
		end
		if (src < 0) begin
			t = -1;
			for (int i = 0; i < num_ports; i++) begin
				if (t < 0 && exp_q[i].size() > 0) begin
					t = exp_q[i][0];
				end
			end
			if (t < 0) begin
				$display("a packet arrived at output %0d while none was pending", o);
				end_in_failure();
			end else begin
				for (int k = 0; k < packet_flits; k++) begin
					compare_flit(test_name[t], flits[t][k], got[o][k]);
				end
			end
		end else begin
			t = exp_q[src].pop_front();
			compare_port(test_name[t], exp_port[t], port_sel_t'(o));
		end
	endtask

	task automatic ack_after_delay(input int o);
		int d;
		d = $unsigned($random(seed)) % 16;
		repeat (d) @(negedge clk);
		out_ack[o] = ~out_ack[o];
	endtask

	task automatic run_receiver(input int o);
		logic req_was;
		int src;
		while (reset !== 1'b0) begin
			@(negedge clk);
		end
		req_was = 1'b0;
		forever begin
			for (int k = 0; k < packet_flits; k++) begin
				while (out_req[o] == req_was) begin
					@(negedge clk);
				end
				req_was = out_req[o];
				got[o][k] = out_flit[o];
				if (k < packet_flits - 1) begin
					ack_after_delay(o);
				end
			end
			find_source(o, src);
			ack_after_delay(o);
			out_acked[src]++;
			rcv_count++;
		end
	endtask

	task automatic run_sender(input int p);
		int t;
		logic ack_was;
		forever begin
			@(negedge clk);
			if (send_q[p].size() > 0) begin
				t = send_q[p].pop_front();
				for (int k = 0; k < packet_flits; k++) begin
					in_flit[p] = flits[t][k];
					@(negedge clk);
					ack_was = in_ack[p];
					in_req[p] = ~in_req[p];
					while (in_ack[p] == ack_was) begin
						@(negedge clk);
					end
				end
				// last input ack must trail the last output ack
				if (out_acked[p] <= pkts_done[p]) begin
					$display("input %0d released test %s before it left the router", p,
						test_name[t]);
					end_in_failure();
				end
				pkts_done[p]++;
				sent_count++;
			end
		end
	endtask

	initial run_sender(0);
	initial run_sender(1);
	initial run_receiver(0);
	initial run_receiver(1);

	initial begin
		reset = 1'b1;
		cfg_we = 1'b0;
		cfg_dest = '0;
		cfg_port = '0;
		for (int p = 0; p < num_ports; p++) begin
			in_req[p] = 1'b0;
			in_flit[p] = '0;
			out_ack[p] = 1'b0;
			out_acked[p] = 0;
			pkts_done[p] = 0;
		end
		for (int d = 0; d < 2**dest_width; d++) begin
			route_model[d] = '0;
		end
		n_tests = 0;
		n_pkts = 0;
		rcv_count = 0;
		sent_count = 0;
		queued = 0;
		read_tests();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		fork
			begin
				repeat (n_pkts * packet_flits * flit_timeout) @(posedge clk);
				$display("timeout with packets missing, %0d of %0d arrived", rcv_count, n_pkts);
				end_in_failure();
			end
		join_none

		for (int t = 0; t < n_tests; t++) begin
			if (is_cfg[t]) begin
				// table changes only between bursts of traffic
				while (rcv_count != queued) begin
					@(negedge clk);
				end
				@(negedge clk);
				cfg_we = 1'b1;
				cfg_dest = line_dest[t];
				cfg_port = line_port[t];
				@(negedge clk);
				cfg_we = 1'b0;
				route_model[line_dest[t]] = line_port[t];
			end else begin
				if (!flits[t][0].head_view.is_head ||
						flits[t][0].head_view.dest != line_dest[t]) begin
					$display("test %s does not start with a head flit for its destination",
						test_name[t]);
					end_in_failure();
				end
				exp_port[t] = route_model[flits[t][0].head_view.dest];
				compare_port(test_name[t], exp_port[t], line_port[t]);
				exp_q[line_inp[t]].push_back(t);
				send_q[line_inp[t]].push_back(t);
				queued++;
			end
		end

		while (sent_count != n_pkts || rcv_count != n_pkts) begin
			@(negedge clk);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== dv/router_tests.txt ====
# name kind(c = config write, p = packet) input dest(hex) flit0..flit7(hex) expected_output
# a config line writes expected_output into the table entry of dest; input and flits unused
def_a p 0 5 85 01 02 03 04 05 06 07 0
def_b p 0 c 8c 08 09 0a 0b 0c 0d 0e 0
def_c p 1 7 87 11 12 13 14 15 16 17 0
cfg_d3 c 0 3 00 00 00 00 00 00 00 00 1
cfg_d9 c 0 9 00 00 00 00 00 00 00 00 1
route_a p 0 3 83 18 19 1a 1b 1c 1d 1e 1
route_b p 0 4 84 21 22 23 24 25 26 27 0
route_c p 1 9 89 28 29 2a 2b 2c 2d 2e 1
route_d p 1 8 88 31 32 33 34 35 36 37 0
par_a p 0 2 82 38 39 3a 3b 3c 3d 3e 0
par_b p 1 3 83 41 42 43 44 45 46 47 1
par_c p 0 6 86 48 49 4a 4b 4c 4d 4e 0
par_d p 1 9 89 51 52 53 54 55 56 57 1
cont_a p 0 9 89 58 59 5a 5b 5c 5d 5e 1
cont_b p 1 3 83 61 62 63 64 65 66 67 1
cont_c p 0 3 83 68 69 6a 6b 6c 6d 6e 1
cont_d p 1 9 89 71 72 73 74 75 76 77 1
cont_e p 0 1 81 78 79 7a 7b 7c 7d 7e 0
cont_f p 1 2 82 01 03 05 07 09 0b 0d 0
cont_g p 0 0 80 02 04 06 08 0a 0c 0e 0
cont_h p 1 f 8f 10 20 30 40 50 60 70 0
cfg_d3_back c 0 3 00 00 00 00 00 00 00 00 0
bp_a p 0 3 83 7f 6f 5f 4f 3f 2f 1f 0
bp_b p 1 9 89 0f 1f 2f 3f 4f 5f 6f 1
bp_c p 0 9 89 7f 7e 7d 7c 7b 7a 79 1
bp_d p 1 3 83 00 00 00 00 00 00 00 0
bp_e p 0 e 8e 55 2a 55 2a 55 2a 55 0
bp_f p 1 e 8e 2a 55 2a 55 2a 55 2a 0

// ==== vlog.f ====
src/noc_pkg.sv
src/sw_if.sv
src/route_table.sv
src/rx_port.sv
src/tx_port.sv
src/switch_alloc.sv
src/noc_router.sv
dv/tb_noc_router.sv

// ==== Bender.yml ====
package:
  name: noc_router

sources:
  - src/noc_pkg.sv
  - src/sw_if.sv
  - src/route_table.sv
  - src/rx_port.sv
  - src/tx_port.sv
  - src/switch_alloc.sv
  - src/noc_router.sv
  - target: test
    files:
      - dv/tb_noc_router.sv
